// File: Bender.yml
package:
  name: bp_frontend

sources:
  - design/bp_pkg.sv
  - design/fetch_pkg.sv
  - design/bp_dpsram.sv
  - design/bp_info_table.sv
  - design/bp_ras.sv
  - design/bp_pcgen.sv
  - design/bp_frontend.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_bp_frontend.sv

// File: design/bp_dpsram.sv
module bp_dpsram #(
  parameter int DATA_WIDTH = 30,
  parameter int DEPTH      = 512
) (
  input  logic                     clk,
  input  logic                     rst_n,
  // read port
  input  logic                     rd_en_i,
  input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
  output logic [DATA_WIDTH-1:0]    rd_data_o,
  // write port
  input  logic                     wr_en_i,
  input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
  input  logic [DATA_WIDTH-1:0]    wr_data_i
);

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // read first, a write shows up on the next read
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];  // holds while stalled
    end
  end

  a_rd_addr_known: assert property (
    @(posedge clk) disable iff (!rst_n) rd_en_i |-> !$isunknown(rd_addr_i)
  );

  a_wr_addr_known: assert property (
    @(posedge clk) disable iff (!rst_n) wr_en_i |-> !$isunknown(wr_addr_i)
  );

endmodule

// File: design/bp_frontend.sv
module bp_frontend #(
  parameter int BTB_DEPTH = 512,
  parameter int RAS_DEPTH = 8
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  bp_pkg::bp_correct_t       correct_i,
  input  logic                      ready_i,
  output logic                      valid_o,
  output logic [31:0]               pc_o,
  output logic [1:0]                mask_o,
  output bp_pkg::bp_predict_t [1:0] predict_o
);

  logic [31:0]            npc;
  bp_pkg::bp_info_t [1:0] info_q;
  logic [1:0][1:0]        ctr;
  logic [1:0][29:0]       btb_rdata;
  logic [31:0]            ras_top_q;
  logic [2:0]             ras_ptr_q;
  logic                   ras_push;
  logic                   ras_pop;
  logic [31:0]            ras_push_addr;

  wire [8:0] btb_raddr = fetch_pkg::btb_index(npc);
  wire [8:0] btb_waddr = fetch_pkg::btb_index(correct_i.pc);
  // returns take their target from the stack
  wire       btb_wr    = correct_i.need_update &&
                         (correct_i.true_type == bp_pkg::BP_TGT_IMM ||
                          correct_i.true_type == bp_pkg::BP_TGT_CALL);
  wire [1:0] btb_we    = {btb_wr && correct_i.pc[2], btb_wr && !correct_i.pc[2]};

  bp_pcgen u_pcgen (
    .clk         (clk),
    .rst_n       (rst_n),
    .ready_i     (ready_i),
    .correct_i   (correct_i),
    .info_q_i    (info_q),
    .ctr_i       (ctr),
    .btb_rdata_i (btb_rdata),
    .ras_top_i   (ras_top_q),
    .ras_ptr_i   (ras_ptr_q),
    .npc_o       (npc),
    .push_o      (ras_push),
    .pop_o       (ras_pop),
    .push_addr_o (ras_push_addr),
    .valid_o     (valid_o),
    .pc_o        (pc_o),
    .mask_o      (mask_o),
    .predict_o   (predict_o)
  );

  bp_dpsram #(
    .DATA_WIDTH (30),
    .DEPTH      (BTB_DEPTH)
  ) u_btb0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_en_i   (ready_i),
    .rd_addr_i (btb_raddr),
    .rd_data_o (btb_rdata[0]),
    .wr_en_i   (btb_we[0]),
    .wr_addr_i (btb_waddr),
    .wr_data_i (correct_i.btb_target[31:2])
  );

  bp_dpsram #(
    .DATA_WIDTH (30),
    .DEPTH      (BTB_DEPTH)
  ) u_btb1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_en_i   (ready_i),
    .rd_addr_i (btb_raddr),
    .rd_data_o (btb_rdata[1]),
    .wr_en_i   (btb_we[1]),
    .wr_addr_i (btb_waddr),
    .wr_data_i (correct_i.btb_target[31:2])
  );

  bp_info_table u_info_table (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_en_i   (ready_i),
    .npc_i     (npc),
    .correct_i (correct_i),
    .info_q_o  (info_q),
    .ctr_o     (ctr)
  );

  bp_ras #(
    .RAS_DEPTH (RAS_DEPTH)
  ) u_ras (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (ras_push),
    .pop_i       (ras_pop),
    .push_addr_i (ras_push_addr),
    .correct_i   (correct_i),
    .top_q_o     (ras_top_q),
    .ptr_o       (ras_ptr_q)
  );

endmodule

// File: design/bp_info_table.sv
module bp_info_table (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rd_en_i,
  input  logic [31:0]            npc_i,
  input  bp_pkg::bp_correct_t    correct_i,
  output bp_pkg::bp_info_t [1:0] info_q_o,
  output logic [1:0][1:0]        ctr_o
);

  localparam int INFO_DEPTH = 128;
  localparam int CTR_DEPTH  = 32;

  bp_pkg::bp_info_t info_wdata;
  logic [6:0]       info_raddr;
  logic [6:0]       info_waddr;
  logic             ctr_we;
  logic [1:0]       ctr_ram [CTR_DEPTH];  // local pattern counters

  assign info_raddr = fetch_pkg::info_index(npc_i);
  assign info_waddr = fetch_pkg::info_index(correct_i.pc);

  always_comb begin
    info_wdata.target_type = correct_i.true_type;
    info_wdata.uncond      = !correct_i.true_cond;
    info_wdata.history     = {correct_i.history[3:0], correct_i.true_taken};
    info_wdata.tag         = fetch_pkg::pc_tag(correct_i.pc);
  end

  for (genvar p = 0; p < 2; p++) begin : g_slot
    bp_pkg::bp_info_t info_ram [INFO_DEPTH];
    bp_pkg::bp_info_t info_q;
    logic             info_we;

    // pc bit 2 picks the slot inside the bundle
    assign info_we = correct_i.need_update && (correct_i.pc[2] == 1'(p));

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        for (int i = 0; i < INFO_DEPTH; i++) begin
          info_ram[i] <= '0;  // empty entry reads as npc
        end
      end else if (info_we) begin
        info_ram[info_waddr] <= info_wdata;
      end
    end

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        info_q <= '0;
      end else if (rd_en_i) begin
        info_q <= info_ram[info_raddr];
      end
    end

    assign info_q_o[p] = info_q;
    assign ctr_o[p]    = ctr_ram[info_q.history];  // second level lookup
  end

  // only conditional branches train the counters
  assign ctr_we = correct_i.need_update && correct_i.true_cond;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < CTR_DEPTH; i++) begin
        ctr_ram[i] <= 2'b00;
      end
    end else if (ctr_we) begin
      ctr_ram[correct_i.history] <= fetch_pkg::next_ctr(correct_i.ctr, correct_i.true_taken);
    end
  end

endmodule

// File: design/bp_pcgen.sv
module bp_pcgen (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ready_i,
  input  bp_pkg::bp_correct_t       correct_i,
  input  bp_pkg::bp_info_t [1:0]    info_q_i,
  input  logic [1:0][1:0]           ctr_i,
  input  logic [1:0][29:0]          btb_rdata_i,
  input  logic [31:0]               ras_top_i,
  input  logic [2:0]                ras_ptr_i,
  output logic [31:0]               npc_o,
  output logic                      push_o,
  output logic                      pop_o,
  output logic [31:0]               push_addr_o,
  output logic                      valid_o,
  output logic [31:0]               pc_o,
  output logic [1:0]                mask_o,
  output bp_pkg::bp_predict_t [1:0] predict_o
);

  logic [31:0]      pc_q;
  logic             mask0_q;   // low when the bundle is entered at pc+4
  logic [31:0]      pc_base;   // 8-aligned bundle address
  logic [1:0]       jump;
  logic [1:0]       take;
  logic [1:0][31:0] slot_tgt;
  logic             take_call;
  logic             take_ret;

  assign pc_o    = pc_q;
  assign pc_base = {pc_q[31:3], 3'b000};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q    <= fetch_pkg::RESET_PC;
      mask0_q <= !fetch_pkg::RESET_PC[2];
    end else if (ready_i) begin
      pc_q    <= npc_o;
      mask0_q <= !npc_o[2];
    end
  end

  for (genvar p = 0; p < 2; p++) begin : g_slot
    logic hit;

    assign hit = (info_q_i[p].target_type != bp_pkg::BP_TGT_NPC) &&
                 (info_q_i[p].tag == fetch_pkg::pc_tag(pc_q));

    // plain imm branches ask the counter
    assign jump[p] = hit && (info_q_i[p].target_type != bp_pkg::BP_TGT_IMM ||
                             info_q_i[p].uncond || ctr_i[p][1]);

    assign slot_tgt[p] = (info_q_i[p].target_type == bp_pkg::BP_TGT_RET) ?
                         ras_top_i : {btb_rdata_i[p], 2'b00};
  end

  assign take[0] = mask0_q && jump[0];
  assign take[1] = !take[0] && jump[1];  // first jumping slot wins

  always_comb begin
    take_call = 1'b0;
    take_ret  = 1'b0;
    for (int p = 0; p < 2; p++) begin
      if (take[p]) begin
        take_call = info_q_i[p].target_type == bp_pkg::BP_TGT_CALL;
        take_ret  = info_q_i[p].target_type == bp_pkg::BP_TGT_RET;
      end
    end
  end

  // next pc select
  always_comb begin
    npc_o = pc_base + fetch_pkg::BUNDLE_STEP;
    if (take[0]) begin
      npc_o = slot_tgt[0];
    end else if (take[1]) begin
      npc_o = slot_tgt[1];
    end
    if (correct_i.redirect) begin
      npc_o = correct_i.true_target;  // back end overrides everything
    end
  end

  // stack moves only for an accepted bundle that is not flushed
  assign push_o      = ready_i && !correct_i.redirect && take_call;
  assign pop_o       = ready_i && !correct_i.redirect && take_ret;
  assign push_addr_o = pc_base + (take[0] ? fetch_pkg::SLOT_STEP : fetch_pkg::BUNDLE_STEP);

  assign valid_o = !correct_i.redirect;
  assign mask_o  = {!take[0], mask0_q};

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      predict_o[p].taken       = take[p];
      predict_o[p].target_type = info_q_i[p].target_type;
      predict_o[p].uncond      = info_q_i[p].uncond;
      predict_o[p].history     = info_q_i[p].history;
      predict_o[p].ctr         = ctr_i[p];
      predict_o[p].ras_ptr     = ras_ptr_i;
      predict_o[p].predict_pc  = npc_o;
    end
  end

  // targets from buffer, stack and redirect all keep word alignment
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n) pc_q[1:0] == 2'b00
  );

endmodule

// File: design/bp_pkg.sv
package bp_pkg;

  // kind of control transfer recorded for one slot
  typedef enum logic [1:0] {
    BP_TGT_NPC  = 2'd0,  // not a branch
    BP_TGT_IMM  = 2'd1,  // direct branch
    BP_TGT_CALL = 2'd2,
    BP_TGT_RET  = 2'd3
  } bp_target_e;

  // one info ram entry, 15 bits
  typedef struct packed {
    bp_target_e  target_type;
    logic        uncond;       // always taken
    logic [4:0]  history;      // local history, newest outcome in bit 0
    logic [6:0]  tag;
  } bp_info_t;

  // per-slot prediction handed to fetch
  typedef struct packed {
    logic        taken;
    bp_target_e  target_type;
    logic        uncond;
    logic [4:0]  history;
    logic [1:0]  ctr;
    logic [2:0]  ras_ptr;      // stack top at prediction time
    logic [31:0] predict_pc;
  } bp_predict_t;

  // feedback from the back end
  typedef struct packed {
    logic        redirect;     // restart fetch at true_target
    logic        need_update;  // write the tables for pc
    logic        miss;
    logic        ras_fix;
    logic [31:0] pc;
    logic [31:0] true_target;
    logic [31:0] btb_target;   // value for the target buffer
    bp_target_e  true_type;
    logic        true_cond;    // set for a conditional branch
    logic        true_taken;
    logic [4:0]  history;      // history the prediction used
    logic [1:0]  ctr;
    logic [2:0]  ras_ptr;
  } bp_correct_t;

endpackage

// File: design/bp_ras.sv
module bp_ras #(
  parameter int RAS_DEPTH = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push_i,
  input  logic                pop_i,
  input  logic [31:0]         push_addr_i,
  input  bp_pkg::bp_correct_t correct_i,
  output logic [31:0]         top_q_o,
  output logic [2:0]          ptr_o
);

  logic [31:0] stack_q [RAS_DEPTH];
  logic [2:0]  ptr_q;   // top entry
  logic [2:0]  wptr_q;  // next free entry
  logic        fix;

  function automatic logic [2:0] wrap_inc(input logic [2:0] ptr);
    return (ptr == 3'(RAS_DEPTH - 1)) ? 3'd0 : ptr + 3'd1;
  endfunction

  function automatic logic [2:0] wrap_dec(input logic [2:0] ptr);
    return (ptr == 3'd0) ? 3'(RAS_DEPTH - 1) : ptr - 3'd1;
  endfunction

  assign fix   = correct_i.miss || correct_i.ras_fix;
  assign ptr_o = ptr_q;

  // top_q_o follows the next top so a return right after a call sees it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q   <= 3'd0;
      wptr_q  <= 3'd1;
      top_q_o <= '0;
      for (int i = 0; i < RAS_DEPTH; i++) begin
        stack_q[i] <= '0;
      end
    end else if (fix) begin
      ptr_q  <= correct_i.ras_ptr;  // repair wins over speculation
      wptr_q <= wrap_inc(correct_i.ras_ptr);
      if (correct_i.true_type == bp_pkg::BP_TGT_CALL) begin
        stack_q[correct_i.ras_ptr] <= correct_i.pc + fetch_pkg::SLOT_STEP;
        top_q_o                    <= correct_i.pc + fetch_pkg::SLOT_STEP;
      end else begin
        top_q_o <= stack_q[correct_i.ras_ptr];
      end
    end else if (push_i) begin
      stack_q[wptr_q] <= push_addr_i;
      ptr_q           <= wrap_inc(ptr_q);
      wptr_q          <= wrap_inc(wptr_q);
      top_q_o         <= push_addr_i;
    end else if (pop_i) begin
      ptr_q   <= wrap_dec(ptr_q);
      wptr_q  <= wrap_dec(wptr_q);
      top_q_o <= stack_q[wrap_dec(ptr_q)];
    end
  end

  // pcgen takes one slot per bundle, never both kinds
  a_no_push_pop: assert property (
    @(posedge clk) disable iff (!rst_n) !(push_i && pop_i)
  );

endmodule

// File: design/fetch_pkg.sv
package fetch_pkg;

  localparam logic [31:0] RESET_PC    = 32'h1c00_0000;
  localparam logic [31:0] BUNDLE_STEP = 32'd8;  // two 4-byte slots
  localparam logic [31:0] SLOT_STEP   = 32'd4;

  function automatic logic [8:0] btb_index(input logic [31:0] pc);
    return pc[11:3];
  endfunction

  function automatic logic [6:0] info_index(input logic [31:0] pc);
    return pc[9:3];
  endfunction

  function automatic logic [6:0] pc_tag(input logic [31:0] pc);
    return pc[16:10];
  endfunction

  // saturating 2-bit counter, msb is the taken guess
  function automatic logic [1:0] next_ctr(input logic [1:0] ctr, input logic taken);
    logic [1:0] nxt;
    if (taken) begin
      nxt = (ctr == 2'b11) ? 2'b11 : ctr + 2'd1;
    end else begin
      nxt = (ctr == 2'b00) ? 2'b00 : ctr - 2'd1;
    end
    return nxt;
  endfunction

endpackage

// File: project.f
+incdir+tb
design/bp_pkg.sv
design/fetch_pkg.sv
design/bp_dpsram.sv
design/bp_info_table.sv
design/bp_ras.sv
design/bp_pcgen.sv
design/bp_frontend.sv
tb/tb_bp_frontend.sv

// File: tb/bp_ref_model.svh
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

// shadow copies of the predictor state, one step per clock
bp_pkg::bp_info_t    m_info   [2][128];
bp_pkg::bp_info_t    m_info_q [2];
logic [29:0]         m_btb    [2][512];
logic [29:0]         m_btb_q  [2];
logic [1:0]          m_ctr    [32];
logic [31:0]         m_stack  [8];
logic [2:0]          m_ptr;
logic [31:0]         m_pc;
logic                m_mask0;

// expected view of the bundle at pc
logic [1:0]          e_take;
logic [1:0]          e_mask;
logic [31:0]         e_npc;
bp_pkg::bp_predict_t e_pred [2];

function automatic logic [1:0] ctr_step(input logic [1:0] c, input logic t);
  if (t) begin
    return (c == 2'b11) ? c : c + 2'b01;
  end
  return (c == 2'b00) ? c : c - 2'b01;
endfunction

function automatic void model_eval(input bp_pkg::bp_correct_t c);
  logic [1:0]  jump;
  logic [31:0] tgt [2];
  for (int p = 0; p < 2; p++) begin
    jump[p] = m_info_q[p].target_type != bp_pkg::BP_TGT_NPC &&
              m_info_q[p].tag == m_pc[16:10] &&
              (m_info_q[p].target_type != bp_pkg::BP_TGT_IMM || m_info_q[p].uncond ||
               m_ctr[m_info_q[p].history][1]);
    tgt[p]  = (m_info_q[p].target_type == bp_pkg::BP_TGT_RET) ? m_stack[m_ptr] :
              {m_btb_q[p], 2'b00};
  end
  e_take[0] = m_mask0 && jump[0];
  e_take[1] = !e_take[0] && jump[1];
  e_mask    = {!e_take[0], m_mask0};
  e_npc     = {m_pc[31:3], 3'b000} + 32'd8;  // fall through
  if (e_take[1]) begin
    e_npc = tgt[1];
  end
  if (e_take[0]) begin
    e_npc = tgt[0];
  end
  if (c.redirect) begin
    e_npc = c.true_target;
  end
  for (int p = 0; p < 2; p++) begin
    e_pred[p].taken       = e_take[p];
    e_pred[p].target_type = m_info_q[p].target_type;
    e_pred[p].uncond      = m_info_q[p].uncond;
    e_pred[p].history     = m_info_q[p].history;
    e_pred[p].ctr         = m_ctr[m_info_q[p].history];
    e_pred[p].ras_ptr     = m_ptr;
    e_pred[p].predict_pc  = e_npc;
  end
endfunction

function automatic void model_step(input bp_pkg::bp_correct_t c, input logic rdy,
                                   input logic rst);
  bp_pkg::bp_target_e ttype;
  logic [31:0]        ret_addr;
  ttype    = e_take[0] ? m_info_q[0].target_type : m_info_q[1].target_type;
  ret_addr = {m_pc[31:3], 3'b000} + (e_take[0] ? 32'd4 : 32'd8);
  // reads see the tables before this clock's writes
  if (rdy) begin
    for (int p = 0; p < 2; p++) begin
      m_btb_q[p] = m_btb[p][e_npc[11:3]];
      if (!rst) begin
        m_info_q[p] = m_info[p][e_npc[9:3]];
      end
    end
    if (!rst) begin
      m_pc    = e_npc;
      m_mask0 = !e_npc[2];
    end
  end
  if (rst) begin
    m_pc    = 32'h1c00_0000;
    m_mask0 = 1'b1;
    m_ptr   = 3'd0;
    for (int p = 0; p < 2; p++) begin
      m_info_q[p] = '0;
      for (int i = 0; i < 128; i++) begin
        m_info[p][i] = '0;
      end
    end
    for (int i = 0; i < 32; i++) begin
      m_ctr[i] = 2'b00;
    end
    for (int i = 0; i < 8; i++) begin
      m_stack[i] = '0;
    end
  end else begin
    if (c.miss || c.ras_fix) begin
      m_ptr = c.ras_ptr;
      if (c.true_type == bp_pkg::BP_TGT_CALL) begin
        m_stack[m_ptr] = c.pc + 32'd4;
      end
    end else if (rdy && !c.redirect && e_take != 2'b00) begin
      if (ttype == bp_pkg::BP_TGT_CALL) begin
        m_ptr          = m_ptr + 3'd1;
        m_stack[m_ptr] = ret_addr;
      end else if (ttype == bp_pkg::BP_TGT_RET) begin
        m_ptr = m_ptr - 3'd1;
      end
    end
    if (c.need_update) begin
      m_info[c.pc[2]][c.pc[9:3]] = '{target_type: c.true_type, uncond: !c.true_cond,
                                     history: {c.history[3:0], c.true_taken},
                                     tag: c.pc[16:10]};
      if (c.true_type == bp_pkg::BP_TGT_IMM || c.true_type == bp_pkg::BP_TGT_CALL) begin
        m_btb[c.pc[2]][c.pc[11:3]] = c.btb_target[31:2];
      end
      if (c.true_cond) begin
        m_ctr[c.history] = ctr_step(c.ctr, c.true_taken);
      end
    end
  end
endfunction

`endif

// File: tb/tb_bp_frontend.sv
module tb_bp_frontend;

  localparam int PH_IDLE     = 30;
  localparam int PH_STALL    = 40;
  localparam int PH_IMM      = 17;
  localparam int PH_COND     = 72;  // 24 rounds of 3
  localparam int PH_CALL     = 17;
  localparam int PH_RANDOM   = 2000;
  localparam int CYCLE_LIMIT = 2 + PH_IDLE + PH_STALL + PH_IMM + PH_COND + PH_CALL +
                               PH_RANDOM + 3 + 100;
  localparam bp_pkg::bp_correct_t NO_CORRECT = '0;

  logic                      clk;
  logic                      rst_n;
  logic                      ready_i;
  bp_pkg::bp_correct_t       correct_i;
  logic                      valid_o;
  logic [31:0]               pc_o;
  logic [1:0]                mask_o;
  bp_pkg::bp_predict_t [1:0] predict_o;
  logic [31:0]               lfsr;
  int                        cycles;
  int                        err_valid;
  int                        err_pc;
  int                        err_mask;
  int                        err_predict;

  `include "bp_ref_model.svh"

  bp_frontend #(
    .BTB_DEPTH (512),
    .RAS_DEPTH (8)
  ) u_bp_frontend (
    .clk       (clk),
    .rst_n     (rst_n),
    .correct_i (correct_i),
    .ready_i   (ready_i),
    .valid_o   (valid_o),
    .pc_o      (pc_o),
    .mask_o    (mask_o),
    .predict_o (predict_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
    end
    return v;
  endfunction

  function automatic bp_pkg::bp_correct_t make_update(input logic [31:0] pc,
      input logic [1:0] kind, input logic cond, input logic taken, input logic [31:0] tgt);
    bp_pkg::bp_correct_t c;
    c             = '0;
    c.need_update = 1'b1;
    c.pc          = pc;
    c.true_type   = bp_pkg::bp_target_e'(kind);
    c.true_cond   = cond;
    c.true_taken  = taken;
    c.true_target = tgt;
    c.btb_target  = tgt;
    c.history     = m_info[pc[2]][pc[9:3]].history;  // what the entry holds now
    c.ctr         = m_ctr[c.history];
    return c;
  endfunction

  function automatic bp_pkg::bp_correct_t make_redirect(input logic [31:0] tgt);
    bp_pkg::bp_correct_t c;
    c             = '0;
    c.redirect    = 1'b1;
    c.true_target = tgt;
    return c;
  endfunction

  task automatic step_cycle(input bp_pkg::bp_correct_t c, input logic rdy);
    @(posedge clk);
    correct_i <= c;
    ready_i   <= rdy;
  endtask

  task automatic check_valid(input logic exp, input logic act);
    if (act !== exp) begin
      err_valid++;
      $display("ERR valid_o exp %h got %h", exp, act);
    end
  endtask

  task automatic check_pc(input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      err_pc++;
      $display("ERR pc_o exp %h got %h", exp, act);
    end
  endtask

  task automatic check_mask(input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      err_mask++;
      $display("ERR mask_o exp %h got %h", exp, act);
    end
  endtask

  task automatic check_predict(input int slot, input bp_pkg::bp_predict_t exp,
                               input bp_pkg::bp_predict_t act);
    if (act !== exp) begin
      err_predict++;
      $display("ERR predict_o[%0d] exp %h got %h", slot, exp, act);
    end
  endtask

  // inputs move on the rising edge, so the falling edge sees a settled bundle
  always @(negedge clk) begin
    model_eval(correct_i);
    if (rst_n) begin
      check_valid(!correct_i.redirect, valid_o);
      check_pc(m_pc, pc_o);
      check_mask(e_mask, mask_o);
      for (int p = 0; p < 2; p++) begin
        check_predict(p, e_pred[p], predict_o[p]);
      end
    end
    model_step(correct_i, ready_i, !rst_n);
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    bp_pkg::bp_correct_t c;
    logic [31:0]         addr;
    logic [31:0]         tgt;
    logic [1:0]          kind;
    logic                cond;
    logic                taken;
    logic                rdy;
    lfsr        = 32'hb901aa89;
    err_valid   = 0;
    err_pc      = 0;
    err_mask    = 0;
    err_predict = 0;
    rst_n       = 1'b0;
    ready_i     = 1'b0;
    correct_i   = NO_CORRECT;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    repeat (PH_IDLE) step_cycle(NO_CORRECT, 1'b1);  // empty tables walk by 8

    for (int i = 0; i < PH_STALL; i++) begin
      if (i == 20) begin
        step_cycle(make_redirect(32'h1c00_0044), 1'b1);  // lands on slot 1
      end else begin
        rdy = 1'(rand_bits(1));
        step_cycle(NO_CORRECT, rdy);
      end
    end

    // always taken branches, one per slot
    step_cycle(make_update(32'h1c00_0100, 2'd1, 1'b0, 1'b1, 32'h1c00_0200), 1'b1);
    step_cycle(make_update(32'h1c00_020c, 2'd1, 1'b0, 1'b1, 32'h1c00_0104), 1'b1);
    step_cycle(make_redirect(32'h1c00_0100), 1'b1);
    repeat (14) step_cycle(NO_CORRECT, 1'b1);

    for (int i = 0; i < PH_COND / 3; i++) begin
      taken = 1'(rand_bits(1));
      step_cycle(make_update(32'h1c00_0180, 2'd1, 1'b1, taken, 32'h1c00_0300), 1'b1);
      step_cycle(make_redirect(32'h1c00_0180), 1'b1);
      step_cycle(NO_CORRECT, 1'b1);
    end

    // call in slot 1, return at the head of the callee's second bundle
    step_cycle(make_update(32'h1c00_0404, 2'd2, 1'b0, 1'b1, 32'h1c00_0500), 1'b1);
    step_cycle(make_update(32'h1c00_0508, 2'd3, 1'b0, 1'b1, 32'h0000_0000), 1'b1);
    step_cycle(make_redirect(32'h1c00_0400), 1'b1);
    repeat (6) step_cycle(NO_CORRECT, 1'b1);
    c           = NO_CORRECT;
    c.ras_fix   = 1'b1;
    c.ras_ptr   = 3'd3;
    c.true_type = bp_pkg::BP_TGT_CALL;
    c.pc        = 32'h1c00_0600;
    step_cycle(c, 1'b0);
    step_cycle(make_redirect(32'h1c00_0508), 1'b1);
    repeat (6) step_cycle(NO_CORRECT, 1'b1);

    for (int i = 0; i < PH_RANDOM; i++) begin
      c     = NO_CORRECT;
      addr  = 32'h1c00_0000 | (rand_bits(8) << 2);
      tgt   = 32'h1c00_0000 | (rand_bits(8) << 2);
      kind  = 2'(rand_bits(2));
      cond  = (kind == 2'd1) && rand_bits(1) != 0;
      taken = 1'(rand_bits(1));
      if (rand_bits(2) == 0) begin
        c = make_update(addr, kind, cond, taken, tgt);
      end
      if (rand_bits(4) == 0) begin
        c.redirect    = 1'b1;
        c.true_target = tgt;
      end
      if (rand_bits(5) == 0) begin
        c.ras_fix = 1'(rand_bits(1));
        c.miss    = !c.ras_fix;
        c.ras_ptr = 3'(rand_bits(3));
      end
      rdy = rand_bits(2) != 0;
      step_cycle(c, rdy);
    end

    repeat (2) step_cycle(NO_CORRECT, 1'b1);
    @(posedge clk);
    $display("errors valid=%0d pc=%0d mask=%0d predict=%0d",
             err_valid, err_pc, err_mask, err_predict);
    if (err_valid + err_pc + err_mask + err_predict == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
